//--- design/burstMarkerGen.sv
`timescale 1ns/1ps
`include "primReplayMacros.svh"

module burstMarkerGen (
   input  logic OSC_50_BANK6,
   input  logic rstN,
   input  logic burst,
   output logic ECRST,
   output logic BCRST,
   output logic syncOut
);
   import ctrlTypesPkg::*;

   localparam int CntW = $clog2(`MARKER_CYCLES + 1);

   logic            burstQ;
   logic            burstPrev;
   logic [CntW-1:0] markCnt;     // Cycles left after this one
   burstMark_t      mark;

   always_ff @(posedge OSC_50_BANK6 or negedge rstN) begin
      if (!rstN) begin
         burstQ    <= 1'b0;
         burstPrev <= 1'b0;
         markCnt   <= '0;
         mark      <= None;
      end else begin
         burstQ    <= burst;
         burstPrev <= burstQ;
         if (burstQ != burstPrev) begin   // Edge restarts the pulse
            mark    <= burstQ ? Sob : Eob;
            markCnt <= CntW'(`MARKER_CYCLES - 1);
         end else if (markCnt != '0) begin
            markCnt <= markCnt - 1'b1;
         end else begin
            mark <= None;
         end
      end
   end

   assign {ECRST, BCRST} = mark;
   assign syncOut        = burstQ;   // Sync line to the second board

endmodule

//--- design/ctrlTypesPkg.sv
package ctrlTypesPkg;

   // Reset sequencer phases
   typedef enum logic [1:0] {
      Idle  = 2'd0,
      Hold  = 2'd1,
      Clear = 2'd2,   // Lane buffers held empty
      Armed = 2'd3
   } rstPhase_t;

   // Marker code packed as {ECRST, BCRST}
   typedef enum logic [1:0] {
      None = 2'b00,
      Eob  = 2'b10,   // End of burst
      Sob  = 2'b11    // Start of burst
   } burstMark_t;

endpackage

//--- design/laneBankIf.sv
`timescale 1ns/1ps
`include "primReplayMacros.svh"

// Write side of the lane buffers as driven by the controller
interface laneBankIf;
   import primTypesPkg::*;

   logic       wrEn;
   laneIdx_t   wrLane;
   primWord_t  wrData;
   logic       clear;                // Empties every lane
   fillLevel_t fill [`NUM_LANES];
   laneMask_t  full;

   modport ctrl (output wrEn, wrLane, wrData, clear, input fill, full);
   modport bank (input wrEn, wrLane, wrData, clear, output fill, full);

endinterface

// Read side towards the drain arbiter
interface laneDrainIf;
   import primTypesPkg::*;

   laneMask_t rdEn;                  // At most one bit set
   primWord_t rdData [`NUM_LANES];   // Head word in the cycle after rdEn
   laneMask_t empty;

   modport bank  (input rdEn, output rdData, empty);
   modport drain (output rdEn, input rdData, empty);

endinterface

//--- design/laneDrainArbiter.sv
`timescale 1ns/1ps
`include "primReplayMacros.svh"

module laneDrainArbiter (
   input  logic                    OSC_50_BANK6,
   input  logic                    rstN,
   input  logic                    txReady,
   output logic                    txValid,
   output primTypesPkg::primWord_t txData,
   output primTypesPkg::laneIdx_t  txLane,
   laneDrainIf.drain               drain
);
   import primTypesPkg::*;

   laneMask_t rdEnReg;
   laneIdx_t  lastLane;   // Lane of the most recent read
   laneIdx_t  nextLane;
   logic      found;
   logic      capture;    // Head word valid on rdData
   logic      inFlight;

   // Round robin picks the first non-empty lane after the last one served
   always_comb begin
      int cand;
      found    = 1'b0;
      nextLane = lastLane;
      for (int k = 1; k <= `NUM_LANES; k++) begin
         cand = int'(lastLane) + k;
         if (cand >= `NUM_LANES) begin
            cand = cand - `NUM_LANES;
         end
         if (!found && !drain.empty[cand]) begin
            found    = 1'b1;
            nextLane = laneIdx_t'(cand);
         end
      end
   end

   assign inFlight = (|rdEnReg) || capture || txValid;   // One word at a time

   always_ff @(posedge OSC_50_BANK6 or negedge rstN) begin
      if (!rstN) begin
         rdEnReg  <= '0;
         lastLane <= laneIdx_t'(`NUM_LANES - 1);   // Lane 0 comes first
         capture  <= 1'b0;
         txValid  <= 1'b0;
      end else begin
         rdEnReg <= '0;
         capture <= |rdEnReg;
         if (!inFlight && txReady && found) begin
            rdEnReg  <= laneMask_t'(1) << nextLane;
            lastLane <= nextLane;
         end
         if (capture) begin
            txValid <= 1'b1;
         end else if (txReady) begin
            txValid <= 1'b0;   // Consumer took the word
         end
      end
   end

   always_ff @(posedge OSC_50_BANK6) begin
      if (capture) begin
         txData <= drain.rdData[lastLane];
         txLane <= lastLane;
      end
   end

   assign drain.rdEn = rdEnReg;

endmodule

//--- design/primLaneBank.sv
`timescale 1ns/1ps
`include "primReplayMacros.svh"

module primLaneBank (
   input logic      OSC_50_BANK6,
   input logic      rstN,
   laneBankIf.bank  bank,
   laneDrainIf.bank drain
);
   import primTypesPkg::*;

   localparam int PtrW = $clog2(`LANE_DEPTH);

   for (genvar i = 0; i < `NUM_LANES; i++) begin : gLane
      primWord_t       mem [`LANE_DEPTH];
      primWord_t       headWord;
      logic [PtrW-1:0] wrPtr;
      logic [PtrW-1:0] rdPtr;
      fillLevel_t      fillCnt;
      logic            wrHit;
      logic            rdHit;

      assign wrHit = bank.wrEn && (bank.wrLane == laneIdx_t'(i)) && !bank.full[i];
      assign rdHit = drain.rdEn[i] && !drain.empty[i];

      always_ff @(posedge OSC_50_BANK6 or negedge rstN) begin
         if (!rstN) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            fillCnt <= '0;
         end else if (bank.clear) begin   // Whole lane dropped at once
            wrPtr   <= '0;
            rdPtr   <= '0;
            fillCnt <= '0;
         end else begin
            if (wrHit) begin
               wrPtr <= wrPtr + 1'b1;     // Wraps with the depth
            end
            if (rdHit) begin
               rdPtr <= rdPtr + 1'b1;
            end
            case ({wrHit, rdHit})
               2'b10:   fillCnt <= fillCnt + 1'b1;
               2'b01:   fillCnt <= fillCnt - 1'b1;
               default: fillCnt <= fillCnt;
            endcase
         end
      end

      // Storage and head word
      always_ff @(posedge OSC_50_BANK6) begin
         if (wrHit) begin
            mem[wrPtr] <= bank.wrData;
         end
         if (rdHit) begin
            headWord <= mem[rdPtr];
         end
      end

      assign bank.fill[i]    = fillCnt;
      assign bank.full[i]    = (fillCnt == fillLevel_t'(`LANE_DEPTH));
      assign drain.empty[i]  = (fillCnt == '0);
      assign drain.rdData[i] = headWord;
   end

endmodule

//--- design/primReplayMacros.svh
`ifndef PRIM_REPLAY_MACROS_SVH
`define PRIM_REPLAY_MACROS_SVH

// ========================================
// Lane buffer geometry
// ========================================
`define NUM_LANES        5
`define PRIM_WIDTH       64
`define LANE_DEPTH       16
`define FILL_WIDTH       5     // Holds 0 up to LANE_DEPTH

// Below this fill a lane asks the host for more words
`define REFILL_THRESHOLD 8

// ========================================
// Reset sequence and burst markers
// ========================================
// Scaled down from 200000 and 65000000 board cycles
`define RST_HOLD_CYCLES  200
`define RST_CLEAR_END    650   // Total count with hold included

`define MARKER_CYCLES    4

`endif

//--- design/primReplayTop.sv
`timescale 1ns/1ps

module primReplayTop (
   input  logic                    OSC_50_BANK6,
   input  logic                    rstN,
   input  logic                    hostReq,
   input  primTypesPkg::laneIdx_t  hostLane,
   input  primTypesPkg::primWord_t hostData,
   input  logic                    ctrlStart,
   input  logic                    startButtonN,
   input  logic                    rearmCmd,
   input  logic [3:0]              detectorUnderInit,
   input  logic                    txReady,
   output logic                    hostAck,
   output logic                    txValid,
   output primTypesPkg::primWord_t txData,
   output primTypesPkg::laneIdx_t  txLane,
   output primTypesPkg::laneMask_t refillIrq,
   output primTypesPkg::laneMask_t polling,
   output logic                    ECRST,
   output logic                    BCRST,
   output logic                    syncOut,
   output logic                    sysReady
);

   logic burst;
   logic clearActive;   // Sequencer holds the lanes empty

   laneBankIf  bankIf ();
   laneDrainIf drainIf ();

   // ========================================
   // Reset and load side
   // ========================================
   resetSequencer resetSeq0 (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .rstN         (rstN),
      .rearmCmd     (rearmCmd),
      .clearActive  (clearActive),
      .sysReady     (sysReady)
   );

   replayController controller0 (
      .OSC_50_BANK6      (OSC_50_BANK6),
      .rstN              (rstN),
      .hostReq           (hostReq),
      .hostLane          (hostLane),
      .hostData          (hostData),
      .ctrlStart         (ctrlStart),
      .startButtonN      (startButtonN),
      .detectorUnderInit (detectorUnderInit),
      .clearActive       (clearActive),
      .hostAck           (hostAck),
      .burst             (burst),
      .refillIrq         (refillIrq),
      .polling           (polling),
      .bank              (bankIf.ctrl)
   );

   primLaneBank laneBank0 (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .rstN         (rstN),
      .bank         (bankIf.bank),
      .drain        (drainIf.bank)
   );

   // Drain stream and burst markers
   laneDrainArbiter drainArb0 (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .rstN         (rstN),
      .txReady      (txReady),
      .txValid      (txValid),
      .txData       (txData),
      .txLane       (txLane),
      .drain        (drainIf.drain)
   );

   burstMarkerGen markerGen0 (
      .OSC_50_BANK6 (OSC_50_BANK6),
      .rstN         (rstN),
      .burst        (burst),
      .ECRST        (ECRST),
      .BCRST        (BCRST),
      .syncOut      (syncOut)
   );

endmodule

//--- design/primTypesPkg.sv
`include "primReplayMacros.svh"

package primTypesPkg;

   // One primitive word as loaded by the host
   typedef logic [`PRIM_WIDTH-1:0] primWord_t;

   // Lane number wide enough for all five ports
   typedef logic [2:0] laneIdx_t;

   typedef logic [`FILL_WIDTH-1:0] fillLevel_t;  // Words held in one lane

   typedef logic [`NUM_LANES-1:0] laneMask_t;    // One bit per lane

endpackage

//--- design/replayController.sv
`timescale 1ns/1ps
`include "primReplayMacros.svh"

module replayController (
   input  logic                    OSC_50_BANK6,
   input  logic                    rstN,
   input  logic                    hostReq,
   input  primTypesPkg::laneIdx_t  hostLane,
   input  primTypesPkg::primWord_t hostData,
   input  logic                    ctrlStart,
   input  logic                    startButtonN,
   input  logic [3:0]              detectorUnderInit,
   input  logic                    clearActive,
   output logic                    hostAck,
   output logic                    burst,
   output primTypesPkg::laneMask_t refillIrq,
   output primTypesPkg::laneMask_t polling,
   laneBankIf.ctrl                 bank
);
   import primTypesPkg::*;

   logic      laneOk;
   logic      laneRoom;
   logic      accept;
   laneMask_t lowMask;

   // ========================================
   // Host load handshake
   // ========================================
   assign laneOk   = (hostLane < `NUM_LANES);
   assign laneRoom = !laneOk || !bank.full[hostLane];   // Bad lane is acked, not stored

   // Fresh request, room in the lane, no clear running
   assign accept = hostReq && !hostAck && !clearActive && laneRoom;

   always_ff @(posedge OSC_50_BANK6 or negedge rstN) begin
      if (!rstN) begin
         hostAck <= 1'b0;
      end else if (accept) begin
         hostAck <= 1'b1;
      end else if (!hostReq) begin
         hostAck <= 1'b0;   // Host has released req
      end
   end

   // Word goes in on the same edge that raises hostAck
   assign bank.wrEn   = accept && laneOk;
   assign bank.wrLane = hostLane;
   assign bank.wrData = hostData;
   assign bank.clear  = clearActive;

   // ========================================
   // Burst and refill requests
   // ========================================
   assign burst = ctrlStart | ~startButtonN;   // Button is active low

   always_comb begin
      for (int i = 0; i < `NUM_LANES; i++) begin
         lowMask[i] = (bank.fill[i] < `REFILL_THRESHOLD);
      end
   end

   always_ff @(posedge OSC_50_BANK6 or negedge rstN) begin
      if (!rstN) begin
         refillIrq <= '0;
         polling   <= '0;
      end else if (burst) begin
         refillIrq <= lowMask;
         polling   <= lowMask;
      end else begin
         // Between bursts the irq lines report detectors still in init
         refillIrq <= laneMask_t'(detectorUnderInit);
         polling   <= '0;
      end
   end

endmodule

//--- design/resetSequencer.sv
`timescale 1ns/1ps
`include "primReplayMacros.svh"

module resetSequencer (
   input  logic OSC_50_BANK6,
   input  logic rstN,
   input  logic rearmCmd,
   output logic clearActive,
   output logic sysReady
);
   import ctrlTypesPkg::*;

   localparam int CntW = $clog2(`RST_CLEAR_END + 1);

   rstPhase_t       phase;
   logic [CntW-1:0] cycleCnt;   // Runs on through Hold and Clear

   always_ff @(posedge OSC_50_BANK6 or negedge rstN) begin
      if (!rstN) begin
         phase    <= Idle;
         cycleCnt <= '0;
      end else begin
         case (phase)
            Idle: begin
               cycleCnt <= '0;
               phase    <= Hold;
            end
            Hold: begin
               if (cycleCnt < CntW'(`RST_HOLD_CYCLES)) begin
                  cycleCnt <= cycleCnt + 1'b1;
               end else begin
                  phase <= Clear;
               end
            end
            Clear: begin
               if (cycleCnt < CntW'(`RST_CLEAR_END)) begin
                  cycleCnt <= cycleCnt + 1'b1;
               end else begin
                  phase <= Armed;
               end
            end
            default: begin   // Armed until a re-arm
               if (rearmCmd) begin
                  phase <= Idle;
               end
            end
         endcase
      end
   end

   assign clearActive = (phase == Clear);
   assign sysReady    = (phase == Armed);

endmodule

//--- run.sh
#!/bin/sh
# Build and run the primitive replay testbench with Verilator

LOG=sim.log

verilator --binary --timing -f vlog.f --top-module primReplayTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VprimReplayTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   exit 1
fi
exit 0

//--- tests/primReplayChecks.svh
`ifndef PRIM_REPLAY_CHECKS_SVH
`define PRIM_REPLAY_CHECKS_SVH

// ========================================
// Reference model
// ========================================
primWord_t laneQ [`NUM_LANES][$];                  // Expected words per lane in load order
laneIdx_t  modelLast   = laneIdx_t'(`NUM_LANES - 1);   // Lane 0 is served first
int        errorCount  = 0;
int        testErrors  = 0;
int        testsRun    = 0;
int        testsFailed = 0;

// Next lane in round-robin order or NUM_LANES when all are empty
function automatic int nextModelLane();
   int cand;
   for (int k = 1; k <= `NUM_LANES; k++) begin
      cand = (int'(modelLast) + k) % `NUM_LANES;
      if (laneQ[cand].size() != 0) begin
         return cand;
      end
   end
   return `NUM_LANES;
endfunction

function automatic laneMask_t lowFillMask();
   laneMask_t mask;
   for (int i = 0; i < `NUM_LANES; i++) begin
      mask[i] = (laneQ[i].size() < `REFILL_THRESHOLD);   // Lane wants a refill
   end
   return mask;
endfunction

function automatic int wordsLeft();
   int total;
   total = 0;
   for (int i = 0; i < `NUM_LANES; i++) begin
      total += laneQ[i].size();
   end
   return total;
endfunction

// ========================================
// Compare tasks
// ========================================
task automatic reportFailure(string what);
   $display("Failure: %s", what);
   errorCount++;
   testErrors++;
endtask

task automatic checkWord(string name, primWord_t got, primWord_t exp);
   if (got !== exp) begin
      $display("Error: %s 0x%h, expected 0x%h", name, got, exp);
      errorCount++;
      testErrors++;
   end
endtask

task automatic checkLane(string name, laneIdx_t got, laneIdx_t exp);
   if (got !== exp) begin
      $display("Error: %s 0x%h, expected 0x%h", name, got, exp);
      errorCount++;
      testErrors++;
   end
endtask

task automatic checkMask(string name, laneMask_t got, laneMask_t exp);
   if (got !== exp) begin
      $display("Error: %s 0x%h, expected 0x%h", name, got, exp);
      errorCount++;
      testErrors++;
   end
endtask

task automatic checkMark(string name, burstMark_t got, burstMark_t exp);
   if (got !== exp) begin
      $display("Error: %s 0x%h, expected 0x%h", name, got, exp);
      errorCount++;
      testErrors++;
   end
endtask

task automatic checkBit(string name, logic got, logic exp);
   if (got !== exp) begin
      $display("Error: %s 0x%h, expected 0x%h", name, got, exp);
      errorCount++;
      testErrors++;
   end
endtask

task automatic finishTest(string name);
   $display("%-26s %0d errors", name, testErrors);
   testsRun++;
   if (testErrors != 0) begin
      testsFailed++;
   end
   testErrors = 0;
endtask

`endif

//--- tests/primReplayTb.sv
`timescale 1ns/1ps
`include "primReplayMacros.svh"

module primReplayTb;
   import primTypesPkg::*;
   import ctrlTypesPkg::*;

   localparam int LoadWords      = 40;
   localparam int RearmWords     = 10;
   localparam int TotalWords     = LoadWords + `LANE_DEPTH + 1 + RearmWords;
   localparam int MarginCycles   = 2000;   // Also covers the second reset sequence
   localparam int WatchdogCycles = `RST_CLEAR_END + 40 * TotalWords + MarginCycles;

   logic       OSC_50_BANK6 = 1'b0;
   logic       rstN;
   logic       hostReq;
   laneIdx_t   hostLane;
   primWord_t  hostData;
   logic       ctrlStart;
   logic       startButtonN;
   logic       rearmCmd;
   logic [3:0] detectorUnderInit;
   logic       txReady;
   logic       hostAck;
   logic       txValid;
   primWord_t  txData;
   laneIdx_t   txLane;
   laneMask_t  refillIrq;
   laneMask_t  polling;
   logic       ECRST;
   logic       BCRST;
   logic       syncOut;
   logic       sysReady;

   int seed = 32'h4134_9c3f;

   `include "primReplayChecks.svh"

   primReplayTop UUT (.*);

   always #5 OSC_50_BANK6 = ~OSC_50_BANK6;   // 100 MHz in simulation

   function automatic burstMark_t markNow();
      return burstMark_t'({ECRST, BCRST});
   endfunction

   // Random lane that still has room in the model
   function automatic laneIdx_t openLane();
      int lane;
      lane = int'($unsigned($random(seed)) % `NUM_LANES);
      while (laneQ[lane].size() >= `LANE_DEPTH) begin
         lane = (lane + 1) % `NUM_LANES;
      end
      return laneIdx_t'(lane);
   endfunction

   // ========================================
   // Stimulus tasks
   // ========================================
   task automatic loadWord(laneIdx_t lane, primWord_t data);
      int ackDelay;
      ackDelay = 0;
      @(negedge OSC_50_BANK6);
      hostReq  = 1'b1;
      hostLane = lane;
      hostData = data;
      do begin
         @(negedge OSC_50_BANK6);
         ackDelay++;
      end while (!hostAck);
      if (ackDelay != 1) begin
         reportFailure($sformatf("hostAck came %0d cycles after hostReq", ackDelay));
      end
      hostReq = 1'b0;
      laneQ[lane].push_back(data);
      @(negedge OSC_50_BANK6);
      if (hostAck !== 1'b0) begin
         reportFailure("hostAck stayed high after hostReq dropped");
      end
   endtask

   // One consumer cycle with the word taken on the next rising edge
   task automatic serviceCycle(logic ready, output logic taken);
      int lane;
      taken = 1'b0;
      @(negedge OSC_50_BANK6);
      txReady = ready;
      if (txValid && ready) begin
         lane = nextModelLane();
         if (lane == `NUM_LANES) begin
            reportFailure("txValid high while the model holds no word");
         end else begin
            checkLane("txLane", txLane, laneIdx_t'(lane));
            checkWord("txData", txData, laneQ[lane].pop_front());
            modelLast = laneIdx_t'(lane);
         end
         taken = 1'b1;
      end
   endtask

   task automatic drainAll();
      logic taken;
      while (wordsLeft() != 0) begin
         serviceCycle(1'($random(seed)), taken);
      end
      serviceCycle(1'b0, taken);
   endtask

   task automatic watchMarker(burstMark_t exp, logic level);
      int delay;
      int len;
      delay = 0;
      len   = 0;
      while (markNow() == None && delay < 8) begin
         @(negedge OSC_50_BANK6);
         delay++;
      end
      if (delay == 8) begin
         reportFailure("no burst marker within 8 cycles of the burst change");
      end else begin
         checkMark("ECRST/BCRST", markNow(), exp);
         checkBit("syncOut", syncOut, level);
         while (markNow() == exp) begin
            len++;
            @(negedge OSC_50_BANK6);
         end
         if (len != `MARKER_CYCLES) begin
            reportFailure($sformatf("marker lasted %0d cycles", len));
         end
      end
      repeat (6) begin   // No second marker
         checkMark("ECRST/BCRST", markNow(), None);
         @(negedge OSC_50_BANK6);
      end
   endtask

   // ========================================
   // Test sequence
   // ========================================
   initial begin
      logic      taken;
      primWord_t word;
      hostReq           = 1'b0;
      hostLane          = '0;
      hostData          = '0;
      ctrlStart         = 1'b0;
      startButtonN      = 1'b1;
      rearmCmd          = 1'b0;
      detectorUnderInit = '0;
      txReady           = 1'b0;
      rstN              = 1'b0;
      repeat (16) @(negedge OSC_50_BANK6);
      checkBit("hostAck", hostAck, 1'b0);
      checkBit("txValid", txValid, 1'b0);
      checkMask("refillIrq", refillIrq, '0);
      checkMask("polling", polling, '0);
      checkMark("ECRST/BCRST", markNow(), None);
      checkBit("syncOut", syncOut, 1'b0);
      checkBit("sysReady", sysReady, 1'b0);
      rstN = 1'b1;
      while (!sysReady) @(negedge OSC_50_BANK6);
      for (int n = 0; n < LoadWords; n++) begin
         loadWord(openLane(), {$random(seed), $random(seed)});
      end
      finishTest("reset and load");

      detectorUnderInit = 4'($random(seed));
      ctrlStart = 1'b1;
      repeat (2) @(negedge OSC_50_BANK6);
      checkMask("refillIrq", refillIrq, lowFillMask());
      checkMask("polling", polling, lowFillMask());
      ctrlStart = 1'b0;
      repeat (2) @(negedge OSC_50_BANK6);
      checkMask("refillIrq", refillIrq, laneMask_t'(detectorUnderInit));
      checkMask("polling", polling, '0);
      finishTest("refill and irq vectors");

      drainAll();
      finishTest("round-robin drain");

      startButtonN = 1'b0;
      watchMarker(Sob, 1'b1);
      startButtonN = 1'b1;
      watchMarker(Eob, 1'b0);
      ctrlStart = 1'b1;
      watchMarker(Sob, 1'b1);
      ctrlStart = 1'b0;
      watchMarker(Eob, 1'b0);
      finishTest("burst markers");

      // Fill lane 2, then one more word has to wait for a drain
      repeat (`LANE_DEPTH) loadWord(laneIdx_t'(2), {$random(seed), $random(seed)});
      word     = {$random(seed), $random(seed)};
      hostReq  = 1'b1;
      hostData = word;
      repeat (10) begin
         @(negedge OSC_50_BANK6);
         checkBit("hostAck", hostAck, 1'b0);
      end
      taken = 1'b0;
      while (!taken) serviceCycle(1'b1, taken);
      serviceCycle(1'b0, taken);
      while (!hostAck) @(negedge OSC_50_BANK6);
      hostReq = 1'b0;
      laneQ[2].push_back(word);
      @(negedge OSC_50_BANK6);
      checkBit("hostAck", hostAck, 1'b0);
      drainAll();
      finishTest("full lane back-pressure");

      for (int n = 0; n < RearmWords; n++) begin
         loadWord(openLane(), {$random(seed), $random(seed)});
      end
      rearmCmd = 1'b1;
      @(negedge OSC_50_BANK6);
      rearmCmd = 1'b0;
      checkBit("sysReady", sysReady, 1'b0);
      while (!sysReady) @(negedge OSC_50_BANK6);
      for (int i = 0; i < `NUM_LANES; i++) begin
         laneQ[i].delete();   // Lanes were emptied by the clear phase
      end
      txReady = 1'b1;
      repeat (20) begin
         @(negedge OSC_50_BANK6);
         checkBit("txValid", txValid, 1'b0);
      end
      txReady = 1'b0;
      finishTest("re-arm clears lanes");

      $display("Tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
      if (errorCount == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WatchdogCycles * 10);
      $display("Watchdog expired after %0d cycles, a wait on the DUT never ended",
               WatchdogCycles);
      $display("Test failed");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+design
+incdir+tests
design/primTypesPkg.sv
design/ctrlTypesPkg.sv
design/laneBankIf.sv
design/replayController.sv
design/primLaneBank.sv
design/laneDrainArbiter.sv
design/burstMarkerGen.sv
design/resetSequencer.sv
design/primReplayTop.sv
tests/primReplayTb.sv
